// File: reg_slice_pipe.f
+incdir+verification
verilog/reg_slice_pkg.sv
verilog/reg_slice_rev.sv
verilog/reg_slice_full.sv
verilog/reg_slice_fwd.sv
verilog/reg_slice_pipe.sv
verification/reg_slice_pipe_tb.sv

// File: verification/reg_slice_pipe_checks.svh
`ifndef REG_SLICE_PIPE_CHECKS_SVH
`define REG_SLICE_PIPE_CHECKS_SVH

// Error counters, one per group of checks
int order_errs    = 0;
int reset_errs    = 0;
int hold_errs     = 0;
int rate_errs     = 0;
int capacity_errs = 0;
int drain_errs    = 0;

////////////////////
// Data path
////////////////////

// Every output word must be the oldest outstanding input word
a_order: assert property (@(posedge ACLK) disable iff (ARESET)
  (m_valid_o && m_ready_i) |-> (sb_count != 0 && m_data_o == exp_head))
  else begin
    order_errs++;
    if ($sampled(sb_count) == 0) begin
      $display("Output transfer seen with no payload outstanding");
    end else begin
      $display("FAILED m_data_o expected %h actual %h", $sampled(exp_head),
               $sampled(m_data_o));
    end
  end

// Quiet handshake while in reset and on the first edge after it
a_reset_quiet: assert property (@(posedge ACLK)
  (past_first_edge && (ARESET || $fell(ARESET))) |-> (!s_ready_o && !m_valid_o))
  else begin
    reset_errs++;
    $display("FAILED s_ready_o expected 0 actual %h, m_valid_o expected 0 actual %h",
             $sampled(s_ready_o), $sampled(m_valid_o));
  end

// Stalled output keeps its word
a_hold: assert property (@(posedge ACLK) disable iff (ARESET)
  (m_valid_o && !m_ready_i) |=> (m_valid_o && $stable(m_data_o)))
  else begin
    hold_errs++;
    $display("FAILED m_valid_o expected 1 actual %h, m_data_o expected %h actual %h",
             $sampled(m_valid_o), $sampled(prev_m_data), $sampled(m_data_o));
  end

////////////////////
// Flow control
////////////////////

// One output word per cycle once free streaming has started
a_full_rate: assert property (@(posedge ACLK) disable iff (ARESET)
  (phase == PH_FREE && out_seen) |-> (m_valid_o && m_ready_i))
  else begin
    rate_errs++;
    $display("FAILED m_valid_o expected 1 actual %h during free streaming",
             $sampled(m_valid_o));
  end

// Source is stopped once the chain is full
a_cap_limit: assert property (@(posedge ACLK) disable iff (ARESET)
  (phase == PH_STALL && stall_accepts >= CAPACITY) |-> !s_ready_o)
  else begin
    capacity_errs++;
    $display("FAILED s_ready_o expected 0 actual %h after %0d accepted words",
             $sampled(s_ready_o), $sampled(stall_accepts));
  end

// Exactly CAPACITY words went in while the sink was stalled
a_cap_reached: assert property (@(posedge ACLK) disable iff (ARESET)
  (phase != PH_STALL && $past(phase) == PH_STALL) |-> (stall_accepts == CAPACITY))
  else begin
    capacity_errs++;
    $display("FAILED stall_accepts expected %h actual %h", CAPACITY,
             $sampled(stall_accepts));
  end

`endif

// File: verification/reg_slice_pipe_tb.sv
`timescale 1ns/1ns

module reg_slice_pipe_tb
  import reg_slice_pkg::*;
;

  ////////////////////
  // Run lengths
  ////////////////////

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 8;
  localparam int IDLE_CYCLES  = 6;
  localparam int FREE_LEN     = 200;
  localparam int RAND_LEN     = 600;
  localparam int STALL_LEN    = 40;
  localparam int DRAIN_LEN    = 40;
  // Generous bound, flush and drain loops have no fixed length
  localparam int WATCHDOG_CYCLES =
    4 * (RESET_CYCLES + IDLE_CYCLES + FREE_LEN + RAND_LEN + STALL_LEN + DRAIN_LEN);

  typedef enum int {PH_IDLE, PH_FREE, PH_RAND, PH_FLUSH, PH_STALL, PH_DRAIN} phase_e;

  logic     ACLK = 1'b0;
  logic     ARESET;
  payload_t s_data_i;
  logic     s_valid_i;
  logic     s_ready_o;
  payload_t m_data_o;
  logic     m_valid_o;
  logic     m_ready_i;

  integer   seed;
  phase_e   phase;
  payload_t data_base;
  int       seq_num;
  // Scoreboard, queue plus registered views for the assertions
  payload_t sb_q [$];
  int       sb_count        = 0;
  payload_t exp_head        = '0;
  payload_t prev_m_data     = '0;
  logic     past_first_edge = 1'b0;
  logic     out_seen        = 1'b0;
  int       stall_accepts   = 0;

  `include "reg_slice_pipe_checks.svh"

  always #(CLK_PERIOD / 2) ACLK = ~ACLK;

  reg_slice_pipe UUT (
    .ACLK      (ACLK),
    .ARESET    (ARESET),
    .s_data_i  (s_data_i),
    .s_valid_i (s_valid_i),
    .s_ready_o (s_ready_o),
    .m_data_o  (m_data_o),
    .m_valid_o (m_valid_o),
    .m_ready_i (m_ready_i)
  );

  // True with the given chance in percent
  function automatic bit roll_percent(input int pct);
    int roll;
    roll = $unsigned($random(seed)) % 100;
    return roll < pct;
  endfunction

  // One clock of source and sink, a word not yet taken stays on the bus
  task automatic step_cycle(input phase_e ph, input bit offer, input bit sink_ready);
    bit held;
    @(posedge ACLK);
    held = s_valid_i && !s_ready_o;
    if (s_valid_i && s_ready_o) begin
      seq_num = seq_num + 1;
    end
    if (!held) begin
      s_valid_i <= offer;
      s_data_i  <= payload_t'(data_base + seq_num);
    end
    phase     <= ph;
    m_ready_i <= sink_ready;
  endtask

  task automatic print_counts;
    $display("Error counts: order %0d, reset %0d, hold %0d, rate %0d, capacity %0d, drain %0d",
             order_errs, reset_errs, hold_errs, rate_errs, capacity_errs, drain_errs);
  endtask

  ////////////////////
  // Scoreboard
  ////////////////////

  always @(posedge ACLK) begin
    past_first_edge <= 1'b1;
    prev_m_data     <= m_data_o;
    if (!ARESET) begin
      // Pop before push, an output never takes a word accepted on the same edge
      if (m_valid_o && m_ready_i && sb_q.size() != 0) begin
        void'(sb_q.pop_front());
      end
      if (s_valid_i && s_ready_o) begin
        sb_q.push_back(s_data_i);
      end
      if (phase == PH_FREE && m_valid_o && m_ready_i) begin
        out_seen <= 1'b1;
      end
      if (phase == PH_STALL && s_valid_i && s_ready_o) begin
        stall_accepts <= stall_accepts + 1;
      end
    end
    sb_count <= sb_q.size();
    exp_head <= (sb_q.size() != 0) ? sb_q[0] : '0;
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    bit want_valid;
    bit want_ready;
    int drain_wait;
    seed      = 32'h20b9ea54;
    ARESET    = 1'b1;
    s_valid_i = 1'b0;
    s_data_i  = '0;
    m_ready_i = 1'b0;
    phase     = PH_IDLE;
    seq_num   = 0;
    data_base = payload_t'($random(seed));
    repeat (RESET_CYCLES) @(posedge ACLK);
    ARESET <= 1'b0;
    repeat (IDLE_CYCLES) step_cycle(PH_IDLE, 1'b0, 1'b1);
    repeat (FREE_LEN) step_cycle(PH_FREE, 1'b1, 1'b1);
    repeat (RAND_LEN) begin
      want_valid = roll_percent(60);
      want_ready = roll_percent(60);
      step_cycle(PH_RAND, want_valid, want_ready);
    end
    // Empty the chain so the stall count starts from zero
    while (s_valid_i || sb_count != 0) step_cycle(PH_FLUSH, 1'b0, 1'b1);
    repeat (STALL_LEN) step_cycle(PH_STALL, 1'b1, 1'b0);
    // Wait for the chain to empty, at most DRAIN_LEN cycles
    drain_wait = 0;
    while ((s_valid_i || sb_count != 0) && drain_wait < DRAIN_LEN) begin
      step_cycle(PH_DRAIN, 1'b0, 1'b1);
      drain_wait++;
    end
    repeat (DRAIN_LEN) step_cycle(PH_DRAIN, 1'b0, 1'b1);
    a_drained: assert (sb_q.size() == 0) else begin
      drain_errs++;
      $display("Scoreboard still holds %0d payloads after the drain", sb_q.size());
    end
    print_counts();
    if (order_errs + reset_errs + hold_errs + rate_errs + capacity_errs + drain_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    print_counts();
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: verilog/reg_slice_full.sv
`timescale 1ns/1ns

module reg_slice_full
  import reg_slice_pkg::*;
(
  input  logic     ACLK,
  input  logic     ARESET,
  // Upstream side
  input  payload_t s_data_i,
  input  logic     s_valid_i,
  output logic     s_ready_o,
  // Downstream side
  output payload_t m_data_o,
  output logic     m_valid_o,
  input  logic     m_ready_i
);

  full_state_e state_q;
  payload_t    data1_q;
  payload_t    data2_q;
  logic        load_s1;
  logic        load_s1_from_s2;
  logic        load_s2;
  logic [1:0]  areset_d;

  // Two-bit reset delay, ready comes up on the second edge after reset
  always_ff @(posedge ACLK) begin
    areset_d <= {areset_d[0], ARESET};
  end

  ////////////////////
  // Payload registers
  ////////////////////

  // Second entry takes every accepted word, needed or not
  assign load_s2 = s_valid_i & s_ready_o;

  // First entry feeds the output
  always_comb begin
    case (state_q)
      // Empty, take the incoming word
      FULL_EMPTY: load_s1 = load_s2;
      // One held, replace it only on a simultaneous in and out transfer
      FULL_ONE:   load_s1 = load_s2 & m_ready_i;
      // Two held, move the older spare forward when the output drains
      FULL_TWO:   load_s1 = m_ready_i;
      default:    load_s1 = 1'b0;
    endcase
  end

  assign load_s1_from_s2 = (state_q == FULL_TWO);

  always_ff @(posedge ACLK) begin
    if (load_s1) begin
      data1_q <= load_s1_from_s2 ? data2_q : s_data_i;
    end
  end

  always_ff @(posedge ACLK) begin
    if (load_s2) begin
      data2_q <= s_data_i;
    end
  end

  ////////////////////
  // Occupancy FSM
  ////////////////////

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      state_q   <= FULL_EMPTY;
      s_ready_o <= 1'b0;
    end else if (areset_d == 2'b10) begin
      s_ready_o <= 1'b1;
    end else if (areset_d == 2'b00) begin
      case (state_q)
        FULL_EMPTY: begin
          if (load_s2) begin
            state_q <= FULL_ONE;
          end
        end
        FULL_ONE: begin
          if (m_ready_i && !load_s2) begin
            state_q <= FULL_EMPTY;
          end else if (!m_ready_i && load_s2) begin
            // Second word arrives under back-pressure, stop the source
            state_q   <= FULL_TWO;
            s_ready_o <= 1'b0;
          end
        end
        FULL_TWO: begin
          if (m_ready_i) begin
            state_q   <= FULL_ONE;
            s_ready_o <= 1'b1;
          end
        end
        default: begin
          state_q   <= FULL_EMPTY;
          s_ready_o <= 1'b0;
        end
      endcase
    end
  end

  assign m_data_o  = data1_q;
  assign m_valid_o = state_q[0];

  // Output held steady until the sink takes it
  a_hold_stall: assert property (@(posedge ACLK) disable iff (ARESET)
    m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_data_o))
    else $error("reg_slice_full: output changed while stalled");

  // No room left when both entries are occupied
  a_two_not_ready: assert property (@(posedge ACLK) disable iff (ARESET)
    (state_q == FULL_TWO) |-> !s_ready_o)
    else $error("reg_slice_full: ready high with two entries held");

endmodule

// File: verilog/reg_slice_fwd.sv
`timescale 1ns/1ns

module reg_slice_fwd
  import reg_slice_pkg::*;
(
  input  logic     ACLK,
  input  logic     ARESET,
  // Upstream side
  input  payload_t s_data_i,
  input  logic     s_valid_i,
  output logic     s_ready_o,
  // Sink side
  output payload_t m_data_o,
  output logic     m_valid_o,
  input  logic     m_ready_i
);

  payload_t   data_q;
  logic       valid_q;
  logic [1:0] areset_d;
  logic       s_take;

  // Reset delay, holds ready off until the chain has settled
  always_ff @(posedge ACLK) begin
    areset_d <= {areset_d[0], ARESET};
  end

  assign s_take = s_valid_i & s_ready_o;

  // Single payload register, loaded on every input transfer
  always_ff @(posedge ACLK) begin
    if (s_take) begin
      data_q <= s_data_i;
    end
  end

  ////////////////////
  // Registered valid
  ////////////////////

  always_ff @(posedge ACLK) begin
    if (ARESET || (areset_d != 2'b00)) begin
      valid_q <= 1'b0;
    end else if (s_take) begin
      valid_q <= 1'b1;
    // Sink took the word and nothing replaced it
    end else if (m_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  assign m_data_o  = data_q;
  assign m_valid_o = valid_q;

  // Room when the sink drains this cycle or the register is empty
  assign s_ready_o = (m_ready_i | ~valid_q) & ~|areset_d;

endmodule

// File: verilog/reg_slice_pipe.sv
`timescale 1ns/1ns

module reg_slice_pipe
  import reg_slice_pkg::*;
(
  input  logic     ACLK,
  input  logic     ARESET,
  // Source side
  input  payload_t s_data_i,
  input  logic     s_valid_i,
  output logic     s_ready_o,
  // Sink side
  output payload_t m_data_o,
  output logic     m_valid_o,
  input  logic     m_ready_i
);

  ////////////////////
  // Link wires
  ////////////////////

  // Link 0 leaves the input slice
  // link NUM_STAGES enters the output slice
  logic     link_valid [0:NUM_STAGES];
  logic     link_ready [0:NUM_STAGES];
  payload_t link_data  [0:NUM_STAGES];

  // Input slice, registers ready toward the source
  reg_slice_rev u_rev (
    .ACLK      (ACLK),
    .ARESET    (ARESET),
    .s_data_i  (s_data_i),
    .s_valid_i (s_valid_i),
    .s_ready_o (s_ready_o),
    .m_data_o  (link_data[0]),
    .m_valid_o (link_valid[0]),
    .m_ready_i (link_ready[0])
  );

  ////////////////////
  // Middle stages
  ////////////////////

  // Each full slice sits between link i and link i+1
  for (genvar i = 0; i < NUM_STAGES; i++) begin : g_full
    reg_slice_full u_full (
      .ACLK      (ACLK),
      .ARESET    (ARESET),
      .s_data_i  (link_data[i]),
      .s_valid_i (link_valid[i]),
      .s_ready_o (link_ready[i]),
      .m_data_o  (link_data[i+1]),
      .m_valid_o (link_valid[i+1]),
      .m_ready_i (link_ready[i+1])
    );
  end

  // Output slice, registers valid and payload toward the sink
  reg_slice_fwd u_fwd (
    .ACLK      (ACLK),
    .ARESET    (ARESET),
    .s_data_i  (link_data[NUM_STAGES]),
    .s_valid_i (link_valid[NUM_STAGES]),
    .s_ready_o (link_ready[NUM_STAGES]),
    .m_data_o  (m_data_o),
    .m_valid_o (m_valid_o),
    .m_ready_i (m_ready_i)
  );

endmodule

// File: verilog/reg_slice_pkg.sv
package reg_slice_pkg;

  ////////////////////
  // Chain dimensions
  ////////////////////

  // Payload width in bits
  localparam int DATA_W = 32;

  // Number of fully registered middle slices, 1 or more
  localparam int NUM_STAGES = 3;

  // Two per full slice, one spare in the input slice, one in the output slice
  localparam int CAPACITY = 2 * NUM_STAGES + 2;

  ////////////////////
  // Types
  ////////////////////

  // Data word carried through every slice
  typedef logic [DATA_W-1:0] payload_t;

  // Occupancy of a full slice, bit 0 doubles as valid out
  typedef enum logic [1:0] {
    FULL_EMPTY = 2'b00,
    FULL_ONE   = 2'b01,
    FULL_TWO   = 2'b11
  } full_state_e;

endpackage

// File: verilog/reg_slice_rev.sv
`timescale 1ns/1ns

module reg_slice_rev
  import reg_slice_pkg::*;
(
  input  logic     ACLK,
  input  logic     ARESET,
  // Source side
  input  payload_t s_data_i,
  input  logic     s_valid_i,
  output logic     s_ready_o,
  // Downstream side
  output payload_t m_data_o,
  output logic     m_valid_o,
  input  logic     m_ready_i
);

  payload_t storage_q;
  logic     has_storage;
  logic     has_storage_nxt;
  logic     areset_d;
  logic     s_take;

  // One-cycle reset delay, keeps valid low just after reset
  always_ff @(posedge ACLK) begin
    areset_d <= ARESET;
  end

  // Input transfer
  assign s_take = s_valid_i & s_ready_o;

  // Spare entry, captures every accepted payload
  always_ff @(posedge ACLK) begin
    if (s_take) begin
      storage_q <= s_data_i;
    end
  end

  ////////////////////
  // Spare entry flag
  ////////////////////

  always_comb begin
    has_storage_nxt = has_storage;
    // Park when downstream cannot take the word
    if (s_take && !m_ready_i) begin
      has_storage_nxt = 1'b1;
    // Parked word leaves and nothing new comes in
    end else if (has_storage && m_ready_i && !s_take) begin
      has_storage_nxt = 1'b0;
    end
  end

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      has_storage <= 1'b0;
      s_ready_o   <= 1'b0;
    end else begin
      has_storage <= has_storage_nxt;
      // Ready while the spare will be free
      // when full, it follows downstream ready one cycle late
      s_ready_o   <= m_ready_i | ~has_storage_nxt;
    end
  end

  // Parked word goes first, otherwise the live input passes straight through
  assign m_data_o  = has_storage ? storage_q : s_data_i;
  assign m_valid_o = (s_valid_i | has_storage) & ~areset_d;

  // The spare must never be overwritten while it still waits for downstream
  a_no_overwrite: assert property (@(posedge ACLK) disable iff (ARESET)
    !(s_take && has_storage && !m_ready_i))
    else $error("reg_slice_rev: input accepted while spare entry is held");

endmodule
